// File: common/eth_stream_pkg.sv
//////////////////////////////
// stream beat types and channel constants
// imported by the switch, the traffic controllers and the top
//////////////////////////////
`default_nettype none

package eth_stream_pkg;

	// the address map has room for two std regions only
	localparam int NUM_CHANNELS = 2;

	typedef logic [63:0] st_data_t;

	// unused bytes in the last word of a packet
	typedef logic [2:0] st_empty_t;

	// one beat, 70 bits; valid and ready travel beside it
	typedef struct packed {
		st_data_t  data;
		st_empty_t empty;
		logic      sop;
		logic      eop;
		logic      error;
	} st_beat_t;

	// switch source slots
	localparam int SRC_ALT = 0;
	localparam int SRC_STD = 1;

endpackage

`default_nettype wire

// File: common/csr_map_pkg.sv
//////////////////////////////
// register bus types, region map and register offsets
//////////////////////////////
`default_nettype none

package csr_map_pkg;

	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;

	// request as driven by the bus master, 48 bits
	typedef struct packed {
		logic      read;
		logic      write;
		csr_addr_t addr;
		csr_data_t wdata;
	} mm_req_t;

	// regions picked by addr[13:12], 4K words each
	typedef enum logic [1:0] {
		REG_ALT  = 2'd0,
		REG_SEL  = 2'd1,
		REG_STD0 = 2'd2,
		REG_STD1 = 2'd3
	} region_t;

	// offset bits inside one region
	localparam int OFS_WIDTH = 12;

	// std controller registers, any other offset reads 0
	localparam csr_addr_t OFS_PKT_COUNT = 14'd0;
	localparam csr_addr_t OFS_PKT_LEN   = 14'd1;
	localparam csr_addr_t OFS_START     = 14'd2;
	localparam csr_addr_t OFS_TX_COUNT  = 14'd3;
	localparam csr_addr_t OFS_RX_GOOD   = 14'd4;
	localparam csr_addr_t OFS_RX_BAD    = 14'd5;

endpackage

`default_nettype wire

// File: logic/csr_fabric.sv
//////////////////////////////
// register bus decode, read return with one wait cycle
// and the path selector register
//////////////////////////////
`default_nettype none

module csr_fabric
	import eth_stream_pkg::*;
	import csr_map_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire mm_req_t   mm_req,
	input  wire csr_data_t std_rdata [NUM_CHANNELS],
	output csr_data_t      mm_rdata,
	output logic           mm_waitrequest,
	output mm_req_t        std_req [NUM_CHANNELS],
	output logic           path_sel
);
	region_t                 region;
	logic                    sel_hit;
	logic [NUM_CHANNELS-1:0] std_hit;
	logic                    rd_done;
	csr_data_t               rd_mux;

	assign region  = region_t'(mm_req.addr[13:12]);
	assign sel_hit = (region == REG_SEL) && (mm_req.addr[OFS_WIDTH-1:0] == '0);

	// std regions follow each other from REG_STD0
	for (genvar i = 0; i < NUM_CHANNELS; i++)
	begin : g_std
		assign std_hit[i]       = (mm_req.addr[13:12] == 2'(int'(REG_STD0) + i));
		assign std_req[i].read  = mm_req.read & std_hit[i];
		assign std_req[i].write = mm_req.write & std_hit[i];
		assign std_req[i].addr  = csr_addr_t'(mm_req.addr[OFS_WIDTH-1:0]);
		assign std_req[i].wdata = mm_req.wdata;
	end

	// alt region is unmapped
	always_comb
	begin
		case (region)
			REG_SEL:  rd_mux = sel_hit ? csr_data_t'(path_sel) : '0;
			REG_STD0: rd_mux = std_rdata[0];
			REG_STD1: rd_mux = std_rdata[1];
			default:  rd_mux = '0;
		endcase
	end

	//////////////////////////////
	// read handshake
	//////////////////////////////

	// first read cycle stalls, the second returns the data
	assign mm_waitrequest = mm_req.read & ~rd_done;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_done  <= 1'b0;
			path_sel <= 1'b0;
		end
		else
		begin
			rd_done <= mm_waitrequest;
			if (mm_req.write && sel_hit)
				path_sel <= mm_req.wdata[0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (mm_waitrequest)
			mm_rdata <= rd_mux;
	end

	// a stalled read stays on the bus with the same address
	a_hold_read: assert property (@(posedge clk) disable iff (rst)
		mm_waitrequest |=> mm_req.read && $stable(mm_req.addr));

endmodule

`default_nettype wire

// File: logic/stream_switch.sv
//////////////////////////////
// per-channel transmit mux and receive demux
// a new select is taken only between packets
//////////////////////////////
`default_nettype none

module stream_switch
	import eth_stream_pkg::*;
(
	input  wire           clk,
	input  wire           rst,
	input  wire           path_sel,
	input  wire st_beat_t src_tx_beat [2],
	input  wire           src_tx_val [2],
	input  wire           mac_tx_ready,
	input  wire st_beat_t mac_rx_beat,
	input  wire           mac_rx_val,
	input  wire           sink_rx_ready [2],
	output logic          src_tx_ready [2],
	output st_beat_t      mac_tx_beat,
	output logic          mac_tx_val,
	output st_beat_t      sink_rx_beat,
	output logic          sink_rx_val [2],
	output logic          mac_rx_ready
);
	localparam int DIR_TX = 0;
	localparam int DIR_RX = 1;

	logic     sel [2];
	logic     dir_val [2];
	logic     dir_rdy [2];
	st_beat_t dir_beat [2];

	// mac side of each direction
	assign dir_val[DIR_TX]  = mac_tx_val;
	assign dir_rdy[DIR_TX]  = mac_tx_ready;
	assign dir_beat[DIR_TX] = mac_tx_beat;
	assign dir_val[DIR_RX]  = mac_rx_val;
	assign dir_rdy[DIR_RX]  = mac_rx_ready;
	assign dir_beat[DIR_RX] = mac_rx_beat;

	for (genvar d = 0; d < 2; d++)
	begin : g_dir
		logic sel_q;
		logic open_q;
		logic xfer;

		// closed direction follows the register straight away
		assign sel[d] = open_q ? sel_q : path_sel;
		assign xfer   = dir_val[d] & dir_rdy[d];

		always_ff @(posedge clk)
		begin
			if (rst)
			begin
				sel_q  <= 1'b0;
				open_q <= 1'b0;
			end
			else
			begin
				sel_q <= sel[d];
				if (xfer && dir_beat[d].eop)
					open_q <= 1'b0;
				else if (xfer && dir_beat[d].sop)
					open_q <= 1'b1;
			end
		end

		// a beat without sop only passes inside an open packet
		a_in_pkt: assert property (@(posedge clk) disable iff (rst)
			xfer && !dir_beat[d].sop |-> open_q);
	end

	assign mac_tx_beat  = src_tx_beat[sel[DIR_TX]];
	assign mac_tx_val   = src_tx_val[sel[DIR_TX]];
	assign sink_rx_beat = mac_rx_beat;
	assign mac_rx_ready = sink_rx_ready[sel[DIR_RX]];

	// unselected side sees ready or valid low
	for (genvar s = 0; s < 2; s++)
	begin : g_src
		assign src_tx_ready[s] = mac_tx_ready & (sel[DIR_TX] == 1'(s));
		assign sink_rx_val[s]  = mac_rx_val & (sel[DIR_RX] == 1'(s));
	end

endmodule

`default_nettype wire

// File: std_tc/std_tc_gen.sv
//////////////////////////////
// packet generator, back-to-back beats with index payload
//////////////////////////////
`default_nettype none

module std_tc_gen
	import eth_stream_pkg::*;
#(
	parameter int CNT_WIDTH = 16
)(
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  start,
	input  wire [CNT_WIDTH-1:0]  pkt_count,
	input  wire [CNT_WIDTH-1:0]  pkt_len,
	input  wire                  tx_ready,
	output st_beat_t             tx_beat,
	output logic                 tx_val,
	output logic [CNT_WIDTH-1:0] tx_count
);
	typedef enum logic {
		GEN_IDLE,
		GEN_SEND
	} gen_state_t;

	gen_state_t           state;
	logic [CNT_WIDTH-1:0] cnt_q;
	logic [CNT_WIDTH-1:0] len_q;
	logic [CNT_WIDTH-1:0] pkt_idx;
	logic [CNT_WIDTH-1:0] beat_idx;
	logic                 xfer;
	logic                 last_beat;

	assign tx_val    = (state == GEN_SEND);
	assign xfer      = tx_val & tx_ready;
	assign last_beat = (beat_idx == len_q - 1'b1);

	// packet index on top, beat index below
	assign tx_beat.data  = {32'(pkt_idx), 32'(beat_idx)};
	assign tx_beat.empty = '0;
	assign tx_beat.sop   = (beat_idx == '0);
	assign tx_beat.eop   = last_beat;
	assign tx_beat.error = 1'b0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= GEN_IDLE;
			pkt_idx  <= '0;
			beat_idx <= '0;
			tx_count <= '0;
		end
		else
		begin
			case (state)
				GEN_IDLE:
				begin
					if (start)
					begin
						pkt_idx  <= '0;
						beat_idx <= '0;
						tx_count <= '0;
						if (pkt_count != '0)
							state <= GEN_SEND;
					end
				end
				GEN_SEND:
				begin
					if (xfer && last_beat)
					begin
						beat_idx <= '0;
						tx_count <= tx_count + 1'b1;
						if (pkt_idx == cnt_q - 1'b1)
							state <= GEN_IDLE;
						else
							pkt_idx <= pkt_idx + 1'b1;
					end
					else if (xfer)
						beat_idx <= beat_idx + 1'b1;
				end
				default: state <= GEN_IDLE;
			endcase
		end
	end

	// run settings, zero length sends single beats
	always_ff @(posedge clk)
	begin
		if (state == GEN_IDLE && start)
		begin
			cnt_q <= pkt_count;
			len_q <= (pkt_len == '0) ? CNT_WIDTH'(1) : pkt_len;
		end
	end

endmodule

`default_nettype wire

// File: std_tc/std_tc_mon.sv
//////////////////////////////
// receive checker, counts good and bad packets
//////////////////////////////
`default_nettype none

module std_tc_mon
	import eth_stream_pkg::*;
#(
	parameter int CNT_WIDTH = 16
)(
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  start,
	input  wire [CNT_WIDTH-1:0]  pkt_count,
	input  wire st_beat_t        rx_beat,
	input  wire                  rx_val,
	input  wire                  stop_mon,
	output logic                 rx_ready,
	output logic [CNT_WIDTH-1:0] rx_good,
	output logic [CNT_WIDTH-1:0] rx_bad,
	output logic                 mon_active,
	output logic                 mon_done,
	output logic                 mon_error
);
	logic [CNT_WIDTH-1:0] beat_idx;
	logic [CNT_WIDTH-1:0] rx_idx;
	logic                 in_pkt;
	logic                 bad_q;
	logic                 bad_now;
	logic                 xfer;
	logic                 armed;
	st_data_t             exp_data;

	// sink never stalls
	assign rx_ready = 1'b1;
	assign xfer     = rx_val & rx_ready;

	// received packet number doubles as expected index
	assign rx_idx   = rx_good + rx_bad;
	assign exp_data = {32'(rx_idx), 32'(beat_idx)};
	assign bad_now  = bad_q | (rx_beat.data != exp_data) | rx_beat.error
		| (!in_pkt & !rx_beat.sop);

	assign mon_error = (rx_bad != '0);

	always_ff @(posedge clk)
	begin
		if (rst || start)
		begin
			beat_idx <= '0;
			in_pkt   <= 1'b0;
			bad_q    <= 1'b0;
			rx_good  <= '0;
			rx_bad   <= '0;
		end
		else if (xfer && rx_beat.eop)
		begin
			beat_idx <= '0;
			in_pkt   <= 1'b0;
			bad_q    <= 1'b0;
			if (bad_now)
				rx_bad <= rx_bad + 1'b1;
			else
				rx_good <= rx_good + 1'b1;
		end
		else if (xfer)
		begin
			beat_idx <= beat_idx + 1'b1;
			in_pkt   <= 1'b1;
			bad_q    <= bad_now;
		end
	end

	//////////////////////////////
	// run status
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			armed      <= 1'b0;
			mon_active <= 1'b0;
			mon_done   <= 1'b0;
		end
		else if (start)
		begin
			armed      <= 1'b1;
			mon_active <= 1'b0;
			mon_done   <= 1'b0;
		end
		else if (armed && (stop_mon || (mon_active && rx_idx >= pkt_count)))
		begin
			armed      <= 1'b0;
			mon_active <= 1'b0;
			mon_done   <= 1'b1;
		end
		else if (armed && xfer && rx_beat.sop)
			mon_active <= 1'b1;
	end

endmodule

`default_nettype wire

// File: std_tc/std_traffic_ctrl.sv
//////////////////////////////
// std channel register block around generator and monitor
//////////////////////////////
`default_nettype none

module std_traffic_ctrl
	import eth_stream_pkg::*;
	import csr_map_pkg::*;
#(
	parameter int CNT_WIDTH = 16
)(
	input  wire           clk,
	input  wire           rst,
	input  wire mm_req_t  req,
	input  wire           tx_ready,
	input  wire st_beat_t rx_beat,
	input  wire           rx_val,
	input  wire           stop_mon,
	output csr_data_t     rdata,
	output st_beat_t      tx_beat,
	output logic          tx_val,
	output logic          rx_ready,
	output logic          mon_active,
	output logic          mon_done,
	output logic          mon_error
);
	logic [CNT_WIDTH-1:0] pkt_count;
	logic [CNT_WIDTH-1:0] pkt_len;
	logic [CNT_WIDTH-1:0] tx_count;
	logic [CNT_WIDTH-1:0] rx_good;
	logic [CNT_WIDTH-1:0] rx_bad;
	logic                 start;

	// start is a write strobe only
	assign start = req.write && (req.addr == OFS_START);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pkt_count <= '0;
			pkt_len   <= '0;
		end
		else if (req.write && req.addr == OFS_PKT_COUNT)
			pkt_count <= CNT_WIDTH'(req.wdata);
		else if (req.write && req.addr == OFS_PKT_LEN)
			pkt_len <= CNT_WIDTH'(req.wdata);
	end

	always_comb
	begin
		rdata = '0;
		if (req.read)
		begin
			case (req.addr)
				OFS_PKT_COUNT: rdata = csr_data_t'(pkt_count);
				OFS_PKT_LEN:   rdata = csr_data_t'(pkt_len);
				OFS_TX_COUNT:  rdata = csr_data_t'(tx_count);
				OFS_RX_GOOD:   rdata = csr_data_t'(rx_good);
				OFS_RX_BAD:    rdata = csr_data_t'(rx_bad);
				default:       rdata = '0;
			endcase
		end
	end

	std_tc_gen #(
		.CNT_WIDTH (CNT_WIDTH)
	) gen_i (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.pkt_count (pkt_count),
		.pkt_len   (pkt_len),
		.tx_ready  (tx_ready),
		.tx_beat   (tx_beat),
		.tx_val    (tx_val),
		.tx_count  (tx_count)
	);

	std_tc_mon #(
		.CNT_WIDTH (CNT_WIDTH)
	) mon_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.pkt_count  (pkt_count),
		.rx_beat    (rx_beat),
		.rx_val     (rx_val),
		.stop_mon   (stop_mon),
		.rx_ready   (rx_ready),
		.rx_good    (rx_good),
		.rx_bad     (rx_bad),
		.mon_active (mon_active),
		.mon_done   (mon_done),
		.mon_error  (mon_error)
	);

endmodule

`default_nettype wire

// File: logic/eth_traffic_ctrl_top.sv
//////////////////////////////
// two-channel traffic controller top
// register fabric, std controllers and stream switches
//////////////////////////////
`default_nettype none

module eth_traffic_ctrl_top
	import eth_stream_pkg::*;
	import csr_map_pkg::*;
#(
	parameter int CNT_WIDTH = 16
)(
	input  wire           clk,
	input  wire           rst,
	input  wire mm_req_t  mm_req,
	input  wire           mac_tx_ready [NUM_CHANNELS],
	input  wire st_beat_t mac_rx_beat [NUM_CHANNELS],
	input  wire           mac_rx_val [NUM_CHANNELS],
	input  wire st_beat_t alt_tx_beat [NUM_CHANNELS],
	input  wire           alt_tx_val [NUM_CHANNELS],
	input  wire           alt_rx_ready [NUM_CHANNELS],
	input  wire           stop_mon [NUM_CHANNELS],
	output csr_data_t     mm_rdata,
	output logic          mm_waitrequest,
	output st_beat_t      mac_tx_beat [NUM_CHANNELS],
	output logic          mac_tx_val [NUM_CHANNELS],
	output logic          mac_rx_ready [NUM_CHANNELS],
	output logic          alt_tx_ready [NUM_CHANNELS],
	output st_beat_t      alt_rx_beat [NUM_CHANNELS],
	output logic          alt_rx_val [NUM_CHANNELS],
	output logic          mon_active [NUM_CHANNELS],
	output logic          mon_done [NUM_CHANNELS],
	output logic          mon_error [NUM_CHANNELS]
);
	mm_req_t   std_req [NUM_CHANNELS];
	csr_data_t std_rdata [NUM_CHANNELS];
	logic      path_sel;

	csr_fabric csr_fabric_i (
		.clk            (clk),
		.rst            (rst),
		.mm_req         (mm_req),
		.std_rdata      (std_rdata),
		.mm_rdata       (mm_rdata),
		.mm_waitrequest (mm_waitrequest),
		.std_req        (std_req),
		.path_sel       (path_sel)
	);

	for (genvar c = 0; c < NUM_CHANNELS; c++)
	begin : g_ch
		st_beat_t sw_tx_beat [2];
		logic     sw_tx_val [2];
		logic     sw_tx_ready [2];
		logic     sw_rx_val [2];
		logic     sw_rx_ready [2];
		st_beat_t sw_rx_beat;

		// alt slot comes straight from the top ports
		assign sw_tx_beat[SRC_ALT]  = alt_tx_beat[c];
		assign sw_tx_val[SRC_ALT]   = alt_tx_val[c];
		assign alt_tx_ready[c]      = sw_tx_ready[SRC_ALT];
		assign alt_rx_beat[c]       = sw_rx_beat;
		assign alt_rx_val[c]        = sw_rx_val[SRC_ALT];
		assign sw_rx_ready[SRC_ALT] = alt_rx_ready[c];

		std_traffic_ctrl #(
			.CNT_WIDTH (CNT_WIDTH)
		) std_tc_i (
			.clk        (clk),
			.rst        (rst),
			.req        (std_req[c]),
			.tx_ready   (sw_tx_ready[SRC_STD]),
			.rx_beat    (sw_rx_beat),
			.rx_val     (sw_rx_val[SRC_STD]),
			.stop_mon   (stop_mon[c]),
			.rdata      (std_rdata[c]),
			.tx_beat    (sw_tx_beat[SRC_STD]),
			.tx_val     (sw_tx_val[SRC_STD]),
			.rx_ready   (sw_rx_ready[SRC_STD]),
			.mon_active (mon_active[c]),
			.mon_done   (mon_done[c]),
			.mon_error  (mon_error[c])
		);

		stream_switch switch_i (
			.clk           (clk),
			.rst           (rst),
			.path_sel      (path_sel),
			.src_tx_beat   (sw_tx_beat),
			.src_tx_val    (sw_tx_val),
			.mac_tx_ready  (mac_tx_ready[c]),
			.mac_rx_beat   (mac_rx_beat[c]),
			.mac_rx_val    (mac_rx_val[c]),
			.sink_rx_ready (sw_rx_ready),
			.src_tx_ready  (sw_tx_ready),
			.mac_tx_beat   (mac_tx_beat[c]),
			.mac_tx_val    (mac_tx_val[c]),
			.sink_rx_beat  (sw_rx_beat),
			.sink_rx_val   (sw_rx_val),
			.mac_rx_ready  (mac_rx_ready[c])
		);
	end

endmodule

`default_nettype wire

// File: sim/tb_checker.sv
//////////////////////////////
// testbench checker, watches the DUT bus and streams
// holds the register model and the per-test error counts
//////////////////////////////
`default_nettype none

module tb_checker
	import eth_stream_pkg::*;
	import csr_map_pkg::*;
(
	input  wire           clk,
	input  wire           rst,
	input  wire mm_req_t  mm_req,
	input  wire csr_data_t mm_rdata,
	input  wire           mm_waitrequest,
	input  wire st_beat_t mac_tx_beat [NUM_CHANNELS],
	input  wire           mac_tx_val [NUM_CHANNELS],
	input  wire           mac_tx_ready [NUM_CHANNELS],
	input  wire st_beat_t alt_tx_beat [NUM_CHANNELS],
	input  wire           alt_tx_val [NUM_CHANNELS],
	input  wire           alt_tx_ready [NUM_CHANNELS],
	input  wire st_beat_t mac_rx_beat [NUM_CHANNELS],
	input  wire           mac_rx_val [NUM_CHANNELS],
	input  wire           mac_rx_ready [NUM_CHANNELS],
	input  wire st_beat_t alt_rx_beat [NUM_CHANNELS],
	input  wire           alt_rx_val [NUM_CHANNELS],
	input  wire           alt_rx_ready [NUM_CHANNELS]
);
	timeunit 1ns;
	timeprecision 1ps;

	csr_data_t reg_model [csr_addr_t];
	string     test_name = "none";
	int        test_errors = 0;
	int        total_errors = 0;
	int        tests_run = 0;
	int        tests_failed = 0;
	// 0 while the alt source is expected at the MAC, 1 for the generator
	bit        gen_mode [NUM_CHANNELS] = '{0, 0};
	int        pkt_i [NUM_CHANNELS] = '{0, 0};
	int        beat_i [NUM_CHANNELS] = '{0, 0};

	// payload rule of the generator
	function automatic st_beat_t expected_beat(int pkt, int beat, int len);
		st_beat_t b;
		int       l;
		l = (len == 0) ? 1 : len;
		b.data  = {pkt[31:0], beat[31:0]};
		b.empty = '0;
		b.sop   = (beat == 0);
		b.eop   = (beat == l - 1);
		b.error = 1'b0;
		return b;
	endfunction

	function automatic void check_value(string what, logic [69:0] exp, logic [69:0] act);
		if (exp !== act)
		begin
			$display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
			test_errors++;
			total_errors++;
		end
	endfunction

	function automatic csr_data_t model_value(csr_addr_t a);
		return reg_model.exists(a) ? reg_model[a] : '0;
	endfunction

	function automatic void set_reg(csr_addr_t a, csr_data_t v);
		reg_model[a] = v;
	endfunction

	function automatic void begin_test(string name);
		test_name   = name;
		test_errors = 0;
	endfunction

	function automatic void end_test();
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %s: %s (%0d errors)", test_name,
			(test_errors == 0) ? "pass" : "FAIL", test_errors);
	endfunction

	function automatic void set_mode(int c, bit m);
		gen_mode[c] = m;
	endfunction

	function automatic void restart_beats(int c);
		pkt_i[c]  = 0;
		beat_i[c] = 0;
	endfunction

	// sampled at the rising edge, before the DUT registers update
	always @(posedge clk)
	begin
		st_beat_t exp_b;
		int       len;
		if (!rst)
		begin
			if (mm_req.read && !mm_waitrequest)
				check_value($sformatf("read %h", mm_req.addr),
					70'(model_value(mm_req.addr)), 70'(mm_rdata));
			// only the configuration registers keep written values
			if (mm_req.write)
			begin
				if (mm_req.addr == {2'd1, 12'd0})
					reg_model[mm_req.addr] = csr_data_t'(mm_req.wdata[0]);
				else if (mm_req.addr[13] && mm_req.addr[11:0] <= 12'd1)
					reg_model[mm_req.addr] = csr_data_t'(mm_req.wdata[15:0]);
			end
			for (int c = 0; c < NUM_CHANNELS; c++)
			begin
				// unselected alt side sees ready or valid low
				check_value($sformatf("ch%0d alt tx ready", c),
					70'(mac_tx_ready[c] & !gen_mode[c]), 70'(alt_tx_ready[c]));
				check_value($sformatf("ch%0d alt rx valid", c),
					70'(mac_rx_val[c] & !gen_mode[c]), 70'(alt_rx_val[c]));
				// the std monitor is always ready
				check_value($sformatf("ch%0d rx ready", c),
					70'(gen_mode[c] ? 1'b1 : alt_rx_ready[c]), 70'(mac_rx_ready[c]));
				if (alt_rx_val[c])
					check_value($sformatf("ch%0d alt rx beat", c), mac_rx_beat[c],
						alt_rx_beat[c]);
				if (!gen_mode[c])
				begin
					check_value($sformatf("ch%0d alt valid", c), 70'(alt_tx_val[c]),
						70'(mac_tx_val[c]));
					if (alt_tx_val[c])
						check_value($sformatf("ch%0d alt beat", c), alt_tx_beat[c],
							mac_tx_beat[c]);
				end
				else if (mac_tx_val[c] && mac_tx_ready[c])
				begin
					len   = int'(model_value({2'(2 + c), 12'd1}));
					exp_b = expected_beat(pkt_i[c], beat_i[c], len);
					check_value($sformatf("ch%0d beat %0d.%0d", c, pkt_i[c], beat_i[c]),
						exp_b, mac_tx_beat[c]);
					if (exp_b.eop)
					begin
						beat_i[c] = 0;
						pkt_i[c]++;
					end
					else
						beat_i[c]++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_top.sv
//////////////////////////////
// testbench top, loopback per channel with random back-pressure
//////////////////////////////
`default_nettype none

module tb_top;
	import eth_stream_pkg::*;
	import csr_map_pkg::*;

	timeunit 1ns;
	timeprecision 1ps;

	// test3 12 + alt 4, test4 22, test5 12, test6 10
	localparam int TOTAL_BEATS = 60;
	localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 500;
	localparam csr_addr_t SEL_ADDR = {2'd1, 12'd0};

	logic      clk;
	logic      rst;
	mm_req_t   mm_req;
	csr_data_t mm_rdata;
	logic      mm_waitrequest;
	logic      mac_tx_ready [NUM_CHANNELS];
	st_beat_t  mac_rx_beat [NUM_CHANNELS];
	logic      mac_rx_val [NUM_CHANNELS];
	st_beat_t  alt_tx_beat [NUM_CHANNELS];
	logic      alt_tx_val [NUM_CHANNELS];
	logic      alt_rx_ready [NUM_CHANNELS];
	logic      stop_mon [NUM_CHANNELS];
	st_beat_t  mac_tx_beat [NUM_CHANNELS];
	logic      mac_tx_val [NUM_CHANNELS];
	logic      mac_rx_ready [NUM_CHANNELS];
	logic      alt_tx_ready [NUM_CHANNELS];
	st_beat_t  alt_rx_beat [NUM_CHANNELS];
	logic      alt_rx_val [NUM_CHANNELS];
	logic      mon_active [NUM_CHANNELS];
	logic      mon_done [NUM_CHANNELS];
	logic      mon_error [NUM_CHANNELS];

	logic      bp_en;
	logic      corrupt_en;
	st_data_t  corrupt_data;
	int        cycles;

	eth_traffic_ctrl_top #(.CNT_WIDTH(16)) eth_traffic_ctrl_top_i (.*);

	tb_checker tb_checker_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// loopback, one chosen beat of channel 0 may be corrupted
	always_comb
	begin
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			mac_rx_beat[c] = mac_tx_beat[c];
			if (c == 0 && corrupt_en && mac_tx_beat[c].data == corrupt_data)
				mac_rx_beat[c].data[0] = ~mac_tx_beat[c].data[0];
			mac_rx_val[c] = mac_tx_val[c] & mac_tx_ready[c];
		end
	end

	// alt sink ready toggles every cycle
	always @(negedge clk)
	begin
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			mac_tx_ready[c] = bp_en ? 1'($urandom % 2) : 1'b1;
			alt_rx_ready[c] = ~alt_rx_ready[c];
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run stopped, no progress within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic csr_addr_t std_addr(int c, csr_addr_t ofs);
		return {2'(2 + c), ofs[11:0]};
	endfunction

	task automatic bus_write(csr_addr_t a, csr_data_t d);
		@(negedge clk);
		mm_req = '{read: 1'b0, write: 1'b1, addr: a, wdata: d};
		@(negedge clk);
		mm_req.write = 1'b0;
	endtask

	// the checker compares the data, here only the wait count
	task automatic bus_read(csr_addr_t a);
		int waits;
		@(negedge clk);
		mm_req = '{read: 1'b1, write: 1'b0, addr: a, wdata: '0};
		waits  = 0;
		do
		begin
			@(negedge clk);
			waits++;
		end
		while (mm_waitrequest);
		@(negedge clk);
		mm_req.read = 1'b0;
		tb_checker_i.check_value("read wait cycles", 70'(1), 70'(waits));
	endtask

	task automatic read_counter(int c, csr_addr_t ofs, int exp);
		tb_checker_i.set_reg(std_addr(c, ofs), csr_data_t'(exp));
		bus_read(std_addr(c, ofs));
	endtask

	task automatic start_channel(int c);
		tb_checker_i.restart_beats(c);
		bus_write(std_addr(c, OFS_START), 32'd1);
	endtask

	initial
	begin
		void'($urandom(59026));
		cycles     = 0;
		rst        = 1'b1;
		mm_req     = '0;
		bp_en      = 1'b0;
		corrupt_en = 1'b0;
		corrupt_data = {32'd1, 32'd2};
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			mac_tx_ready[c] = 1'b1;
			alt_tx_beat[c]  = '0;
			alt_tx_val[c]   = 1'b0;
			alt_rx_ready[c] = 1'b1;
			stop_mon[c]     = 1'b0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		//////////////////////////////
		// reset state and registers
		//////////////////////////////
		tb_checker_i.begin_test("reset");
		bus_read(SEL_ADDR);
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			read_counter(c, OFS_TX_COUNT, 0);
			read_counter(c, OFS_RX_GOOD, 0);
			read_counter(c, OFS_RX_BAD, 0);
			tb_checker_i.check_value("mon_active", 0, 70'(mon_active[c]));
			tb_checker_i.check_value("mon_done", 0, 70'(mon_done[c]));
			tb_checker_i.check_value("mon_error", 0, 70'(mon_error[c]));
			tb_checker_i.check_value("tx valid", 0, 70'(mac_tx_val[c]));
		end
		bus_read({2'd0, 12'h010});
		tb_checker_i.end_test();

		tb_checker_i.begin_test("readback");
		bus_write(std_addr(0, OFS_PKT_COUNT), 32'd3);
		bus_write(std_addr(0, OFS_PKT_LEN), 32'd4);
		bus_write(std_addr(1, OFS_PKT_COUNT), 32'd2);
		bus_write(std_addr(1, OFS_PKT_LEN), 32'd5);
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			bus_read(std_addr(c, OFS_PKT_COUNT));
			bus_read(std_addr(c, OFS_PKT_LEN));
			bus_read(std_addr(c, OFS_START));
		end
		tb_checker_i.end_test();

		//////////////////////////////
		// path selection
		//////////////////////////////
		tb_checker_i.begin_test("switch");
		start_channel(0);
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			alt_tx_val[0]  = 1'b1;
			alt_tx_beat[0] = '{data: {$urandom, $urandom}, empty: '0,
				sop: 1'b1, eop: 1'b1, error: 1'b0};
		end
		@(negedge clk);
		alt_tx_val[0] = 1'b0;
		read_counter(0, OFS_TX_COUNT, 0);
		bus_write(SEL_ADDR, 32'd1);
		tb_checker_i.set_mode(0, 1'b1);
		tb_checker_i.set_mode(1, 1'b1);
		bus_read(SEL_ADDR);
		tb_checker_i.check_value("alt ready", 0, 70'(alt_tx_ready[0]));
		wait (mon_done[0]);
		read_counter(0, OFS_TX_COUNT, 3);
		tb_checker_i.end_test();

		tb_checker_i.begin_test("traffic");
		bp_en = 1'b1;
		start_channel(0);
		start_channel(1);
		wait (mon_done[0] && mon_done[1]);
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			read_counter(c, OFS_TX_COUNT, (c == 0) ? 3 : 2);
			read_counter(c, OFS_RX_GOOD, (c == 0) ? 3 : 2);
			tb_checker_i.check_value("mon_error", 0, 70'(mon_error[c]));
		end
		tb_checker_i.end_test();

		tb_checker_i.begin_test("corrupt");
		corrupt_en = 1'b1;
		start_channel(0);
		wait (mon_done[0]);
		read_counter(0, OFS_RX_BAD, 1);
		read_counter(0, OFS_RX_GOOD, 2);
		tb_checker_i.check_value("mon_error", 1, 70'(mon_error[0]));
		corrupt_en = 1'b0;
		tb_checker_i.end_test();

		// stop the monitor part way through channel 1
		tb_checker_i.begin_test("stop");
		start_channel(1);
		wait (mon_active[1]);
		@(negedge clk);
		stop_mon[1] = 1'b1;
		@(negedge clk);
		stop_mon[1] = 1'b0;
		wait (mon_done[1]);
		@(negedge clk);
		tb_checker_i.check_value("mon_active", 0, 70'(mon_active[1]));
		// done came from the stop, the generator is still sending
		tb_checker_i.check_value("tx valid at stop", 1, 70'(mac_tx_val[1]));
		while (mac_tx_val[1])
			@(negedge clk);
		tb_checker_i.end_test();

		$display("tests %0d, failed %0d, errors %0d", tb_checker_i.tests_run,
			tb_checker_i.tests_failed, tb_checker_i.total_errors);
		if (tb_checker_i.total_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
common/eth_stream_pkg.sv
common/csr_map_pkg.sv
logic/csr_fabric.sv
logic/stream_switch.sv
std_tc/std_tc_gen.sv
std_tc/std_tc_mon.sv
std_tc/std_traffic_ctrl.sv
logic/eth_traffic_ctrl_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
